// File: files.f
source/exc_pkg.sv
source/exc_event_sampler.sv
source/exc_controller.sv
source/exc_flush_sequencer.sv
source/exc_trap_csr.sv
source/exc_subsystem_top.sv
verif/exc_subsystem_assertions.sv
verif/exc_subsystem_tb.sv

// File: verif/exc_subsystem_tb.sv
////////////////////
// testbench for the trap-entry subsystem
// drives exceptions, interrupts, returns, debug settings and stalls
// a reference model predicts every handler entry, a compare process checks it
////////////////////

`timescale 1ns/100ps

module exc_subsystem_tb;

  localparam int          CLK_PERIOD = 4;
  localparam int          PIPE_DEPTH = 3;
  localparam logic [31:0] VEC_BASE   = 32'h0000_1000;
  localparam int          N_PRIO     = 12;
  // single, priority, irq on, irq off, debug, single-step, stall
  localparam int          N_TESTS    = 8 + 2 * N_PRIO + 8 + 6 + 20 + 2 + 16;
  localparam int          WD_CYCLES  = N_TESTS * (PIPE_DEPTH + 20);

  // architectural state as the model sees it after one event
  typedef struct packed {
    logic        valid;
    logic        trap;
    logic [5:0]  cause;
    logic [31:0] epc;
    logic [31:0] handler;
    logic        en;
    logic        en_saved;
  } model_t;

  logic        clk;
  logic        rst_n;
  logic        illegal_i;
  logic        ecall_i;
  logic        ebreak_i;
  logic        eret_i;
  logic        load_err_i;
  logic        store_err_i;
  logic        irq_i;
  logic [4:0]  irq_id_i;
  logic [31:0] pc_i;
  logic [5:0]  dbg_settings_i;
  logic        stall_i;
  logic        trap_o;
  logic [5:0]  cause_o;
  logic [31:0] epc_o;
  logic [31:0] handler_pc_o;
  logic        handler_valid_o;
  logic        irq_enable_o;

  integer              seed;
  logic [31:0]         rnd;
  int                  err_cnt;
  int                  chk_cnt;
  int                  n;
  int                  k;
  model_t              model;
  model_t              cur;
  string               cur_name;
  model_t              exp_q[$];
  string               name_q[$];
  exc_pkg::exc_event_t ev;

  exc_subsystem_top #(
    .PIPE_DEPTH (PIPE_DEPTH),
    .VEC_BASE   (VEC_BASE)
  ) UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .illegal_i       (illegal_i),
    .ecall_i         (ecall_i),
    .ebreak_i        (ebreak_i),
    .eret_i          (eret_i),
    .load_err_i      (load_err_i),
    .store_err_i     (store_err_i),
    .irq_i           (irq_i),
    .irq_id_i        (irq_id_i),
    .pc_i            (pc_i),
    .dbg_settings_i  (dbg_settings_i),
    .stall_i         (stall_i),
    .trap_o          (trap_o),
    .cause_o         (cause_o),
    .epc_o           (epc_o),
    .handler_pc_o    (handler_pc_o),
    .handler_valid_o (handler_valid_o),
    .irq_enable_o    (irq_enable_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // reference model
  ////////////////////

  // store > load > illegal > ecall > irq, ebreak only feeds the debug trap
  function automatic model_t exp_trap(input exc_pkg::exc_event_t e, input logic [5:0] dbg,
                                      input logic [31:0] pc, input model_t st);
    model_t r;
    logic   irq_on;
    logic   taken;
    r       = st;
    r.valid = 1'b0;
    irq_on  = e.irq & st.en;
    taken   = 1'b1;
    r.trap  = dbg[exc_pkg::DBG_SSTE]
            | (e.ecall & dbg[exc_pkg::DBG_ECALL])
            | ((e.load_err | e.store_err) & dbg[exc_pkg::DBG_ELSU])
            | (e.ebreak & dbg[exc_pkg::DBG_EBRK])
            | (e.illegal & dbg[exc_pkg::DBG_EILL])
            | (irq_on & dbg[exc_pkg::DBG_IRQ]);
    if (e.store_err) begin
      r.cause   = {1'b0, exc_pkg::CODE_STORE};
      r.handler = VEC_BASE + 32'h8C;
    end else if (e.load_err) begin
      r.cause   = {1'b0, exc_pkg::CODE_LOAD};
      r.handler = VEC_BASE + 32'h88;
    end else if (e.illegal) begin
      r.cause   = {1'b0, exc_pkg::CODE_ILLEGAL};
      r.handler = VEC_BASE + 32'h84;
    end else if (e.ecall) begin
      r.cause   = {1'b0, exc_pkg::CODE_ECALL};
      r.handler = VEC_BASE + 32'h80;
    end else if (irq_on) begin
      r.cause   = {1'b1, e.irq_id};
      r.handler = VEC_BASE + 32'(e.irq_id) * 4;
    end else begin
      taken = 1'b0;
    end
    if (taken) begin
      r.valid    = 1'b1;
      r.epc      = pc;
      r.en_saved = st.en;
      r.en       = 1'b0;
    end else if (e.eret) begin
      // return jumps to epc and restores the saved enable
      r.valid   = 1'b1;
      r.handler = st.epc;
      r.en      = st.en_saved;
    end
    return r;
  endfunction

  function automatic exc_pkg::exc_event_t single_event(input int sel);
    exc_pkg::exc_event_t e;
    e = '0;
    case (sel)
      0:       e.illegal   = 1'b1;
      1:       e.ecall     = 1'b1;
      2:       e.load_err  = 1'b1;
      3:       e.store_err = 1'b1;
      4:       e.ebreak    = 1'b1;
      default: e.eret      = 1'b1;
    endcase
    return e;
  endfunction

  function automatic string event_name(input int sel);
    case (sel)
      0:       return "illegal";
      1:       return "ecall";
      2:       return "load_err";
      3:       return "store_err";
      4:       return "ebreak";
      default: return "eret";
    endcase
  endfunction

  ////////////////////
  // compare
  ////////////////////

  // outputs settle after the rising edge, sampled at the falling one
  always @(negedge clk) begin
    if (rst_n && handler_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("handler_valid_o came with no trap or return pending at %0t", $time);
        err_cnt++;
      end else begin
        cur      = exp_q.pop_front();
        cur_name = name_q.pop_front();
        chk_cnt++;
        if (cause_o !== cur.cause) begin
          $display("ERROR %s: cause_o expected %h got %h", cur_name, cur.cause, cause_o);
          err_cnt++;
        end
        if (epc_o !== cur.epc) begin
          $display("ERROR %s: epc_o expected %h got %h", cur_name, cur.epc, epc_o);
          err_cnt++;
        end
        if (handler_pc_o !== cur.handler) begin
          $display("ERROR %s: handler_pc_o expected %h got %h", cur_name, cur.handler,
                   handler_pc_o);
          err_cnt++;
        end
        if (irq_enable_o !== cur.en) begin
          $display("ERROR %s: irq_enable_o expected %b got %b", cur_name, cur.en,
                   irq_enable_o);
          err_cnt++;
        end
      end
    end
  end

  ////////////////////
  // stimulus tasks
  ////////////////////

  task automatic drive_event(input exc_pkg::exc_event_t e);
    illegal_i   = e.illegal;
    ecall_i     = e.ecall;
    ebreak_i    = e.ebreak;
    eret_i      = e.eret;
    load_err_i  = e.load_err;
    store_err_i = e.store_err;
  endtask

  // waits until the compare process has taken the entry, or a quiet window
  task automatic wait_result(input string name, input logic valid);
    int waited;
    waited = 0;
    if (valid) begin
      while (exp_q.size() != 0 && waited < PIPE_DEPTH + 12) begin
        @(posedge clk);
        waited++;
      end
      if (exp_q.size() != 0) begin
        $display("%s: handler_valid_o never came", name);
        err_cnt++;
        exp_q.delete();
        name_q.delete();
      end
    end else begin
      repeat (PIPE_DEPTH + 10) @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  // one decoder or lsu pulse, called 1 ns after a rising edge
  task automatic run_case(input string name, input exc_pkg::exc_event_t e,
                          input logic stall_on);
    model_t      nxt;
    logic [31:0] pc;
    int          unstalled;
    pc      = $random(seed);
    pc[1:0] = 2'b00;
    nxt     = exp_trap(e, dbg_settings_i, pc, model);
    model   = nxt;
    if (nxt.valid) begin
      exp_q.push_back(nxt);
      name_q.push_back(name);
    end
    drive_event(e);
    pc_i = pc;
    @(posedge clk);
    #1;
    drive_event('0);
    if (stall_on) begin
      stall_i = ($random(seed) % 2) != 0;
    end
    // event sits in the registered word during this cycle
    @(negedge clk);
    if (trap_o !== nxt.trap) begin
      $display("ERROR %s: trap_o expected %b got %b", name, nxt.trap, trap_o);
      err_cnt++;
    end
    if (stall_on && nxt.valid && !e.eret) begin
      // count edges that see stall low, ack lands on the last of them
      unstalled = 0;
      while (unstalled < PIPE_DEPTH) begin
        @(posedge clk);
        if (!stall_i) begin
          unstalled++;
        end
        #1;
        stall_i = ($random(seed) % 2) != 0;
      end
      @(negedge clk);
      if (handler_valid_o) begin
        $display("%s: handler_valid_o came before %0d unstalled cycles", name, PIPE_DEPTH);
        err_cnt++;
      end
      @(posedge clk);
      #1;
      stall_i = 1'b0;
      @(negedge clk);
      if (!handler_valid_o) begin
        $display("%s: handler_valid_o missing after %0d unstalled cycles", name, PIPE_DEPTH);
        err_cnt++;
      end
    end
    wait_result(name, nxt.valid);
  endtask

  // interrupt level held until the handler entry, pc kept steady meanwhile
  task automatic run_irq(input string name);
    model_t              nxt;
    exc_pkg::exc_event_t e;
    e        = '0;
    rnd      = $random(seed);
    e.irq    = 1'b1;
    e.irq_id = rnd[4:0];
    pc_i     = $random(seed);
    pc_i[1:0] = 2'b00;
    nxt      = exp_trap(e, dbg_settings_i, pc_i, model);
    model    = nxt;
    if (nxt.valid) begin
      exp_q.push_back(nxt);
      name_q.push_back(name);
    end
    irq_id_i = e.irq_id;
    irq_i    = 1'b1;
    // level reaches the event word on the third edge
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (trap_o !== nxt.trap) begin
      $display("ERROR %s: trap_o expected %b got %b", name, nxt.trap, trap_o);
      err_cnt++;
    end
    wait_result(name, nxt.valid);
    irq_i = 1'b0;
    // let the synchronizer drain before the next event
    repeat (6) @(posedge clk);
    #1;
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    seed           = 32'h4f8db57c;
    err_cnt        = 0;
    chk_cnt        = 0;
    clk            = 1'b0;
    rst_n          = 1'b0;
    irq_i          = 1'b0;
    irq_id_i       = '0;
    pc_i           = '0;
    dbg_settings_i = '0;
    stall_i        = 1'b0;
    drive_event('0);
    model          = '0;
    model.en       = 1'b1;
    model.en_saved = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // each exception alone, then return
    for (k = 0; k < 4; k++) begin
      run_case($sformatf("single %s", event_name(k)), single_event(k), 1'b0);
      run_case("single eret", single_event(5), 1'b0);
    end

    // simultaneous strobes
    for (n = 0; n < N_PRIO; n++) begin
      rnd          = $random(seed);
      ev           = '0;
      ev.illegal   = rnd[0];
      ev.ecall     = rnd[1];
      ev.ebreak    = rnd[2];
      ev.load_err  = rnd[3];
      ev.store_err = rnd[4];
      run_case("priority", ev, 1'b0);
      run_case("priority eret", single_event(5), 1'b0);
    end

    // interrupts with the enable set, debug trap armed on the irq bit
    for (n = 0; n < 4; n++) begin
      dbg_settings_i = 6'b1 << exc_pkg::DBG_IRQ;
      run_irq("irq enabled");
      dbg_settings_i = '0;
      run_case("irq eret", single_event(5), 1'b0);
    end
    // a trap without return leaves the enable cleared
    for (n = 0; n < 2; n++) begin
      run_case("irq mask trap", single_event(1), 1'b0);
      dbg_settings_i = 6'b1 << exc_pkg::DBG_IRQ;
      run_irq("irq disabled");
      dbg_settings_i = '0;
      run_case("irq mask eret", single_event(5), 1'b0);
    end

    // per-cause debug settings, all set first then random
    for (n = 0; n < 2; n++) begin
      for (k = 0; k < 5; k++) begin
        rnd = $random(seed);
        dbg_settings_i = (n == 0) ? 6'h3f : rnd[5:0];
        dbg_settings_i[exc_pkg::DBG_SSTE] = 1'b0;
        run_case($sformatf("debug %s", event_name(k)), single_event(k), 1'b0);
        dbg_settings_i = '0;
        run_case("debug eret", single_event(5), 1'b0);
      end
    end

    // single-step keeps the trap up on every cycle
    dbg_settings_i = 6'b1 << exc_pkg::DBG_SSTE;
    repeat (4) begin
      @(negedge clk);
      if (trap_o !== 1'b1) begin
        $display("ERROR single step: trap_o expected 1 got %b", trap_o);
        err_cnt++;
      end
    end
    @(posedge clk);
    #1;
    run_case("single step ecall", single_event(1), 1'b0);
    run_case("single step eret", single_event(5), 1'b0);
    dbg_settings_i = '0;

    // random back-pressure on the drain
    for (n = 0; n < 8; n++) begin
      run_case($sformatf("stall %s", event_name(n % 4)), single_event(n % 4), 1'b1);
      run_case("stall eret", single_event(5), 1'b0);
    end

    err_cnt = err_cnt + UUT.u_controller.u_assertions.fail_cnt;
    $display("handler entries checked: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WD_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: verif/exc_subsystem_assertions.sv
////////////////////
// request/acknowledge protocol checks for the exception controller
// bound into every exc_controller instance
////////////////////

`timescale 1ns/100ps

module exc_subsystem_assertions (
  input logic       clk,
  input logic       rst_n,
  input logic       int_req_i,
  input logic       ext_req_i,
  input logic       ack_i,
  input logic       save_cause_i,
  input logic       ebreak_i,
  input logic [5:0] cause_i,
  input logic [2:0] vec_sel_i
);

  // number of failed assertions so far
  int fail_cnt = 0;

  // only one request kind at a time
  a_req_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(int_req_i && ext_req_i)) else begin
    $error("int_req and ext_req high together");
    fail_cnt++;
  end

  // a raised request stays up until the flush sequencer acks
  a_int_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (int_req_i && !ack_i) |=> int_req_i) else begin
    $error("int_req dropped before ack");
    fail_cnt++;
  end

  a_ext_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ext_req_i && !ack_i) |=> ext_req_i) else begin
    $error("ext_req dropped before ack");
    fail_cnt++;
  end

  // held cause and vector, ebreak bypasses the cause for debug only
  a_cause_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ((int_req_i || ext_req_i) && !ack_i)
      |=> (ebreak_i || ($stable(cause_i) && $stable(vec_sel_i)))) else begin
    $error("cause or vector changed while waiting for ack");
    fail_cnt++;
  end

  // ack only comes for a pending request, so every ack saves the cause
  a_save_ack: assert property (@(posedge clk) disable iff (!rst_n)
    save_cause_i == ack_i) else begin
    $error("save_cause and ack disagree");
    fail_cnt++;
  end

endmodule

bind exc_controller exc_subsystem_assertions u_assertions (
  .clk          (clk),
  .rst_n        (rst_n),
  .int_req_i    (int_req_o),
  .ext_req_i    (ext_req_o),
  .ack_i        (ack_i),
  .save_cause_i (save_cause_o),
  .ebreak_i     (ev_i.ebreak),
  .cause_i      (cause_o),
  .vec_sel_i    (vec_sel_o)
);

// File: source/exc_subsystem_top.sv
////////////////////
// top of the trap-entry subsystem
// wires sampler, controller, flush sequencer and csr block, passes parameters down
////////////////////

`timescale 1ns/100ps

module exc_subsystem_top #(
  parameter int          PIPE_DEPTH = 3,
  parameter logic [31:0] VEC_BASE   = 32'h0000_1000
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           illegal_i,
  input  logic                           ecall_i,
  input  logic                           ebreak_i,
  input  logic                           eret_i,
  input  logic                           load_err_i,
  input  logic                           store_err_i,
  input  logic                           irq_i,
  input  logic [4:0]                     irq_id_i,
  input  logic [31:0]                    pc_i,
  input  logic [exc_pkg::DBG_SETS_W-1:0] dbg_settings_i,
  input  logic                           stall_i,
  output logic                           trap_o,
  output logic [5:0]                     cause_o,
  output logic [31:0]                    epc_o,
  output logic [31:0]                    handler_pc_o,
  output logic                           handler_valid_o,
  output logic                           irq_enable_o
);

  exc_pkg::exc_event_t ev;
  logic [31:0]         pc_q;
  logic                int_req;
  logic                ext_req;
  logic                ack;
  logic                save_cause;
  exc_pkg::exc_cause_u cause;
  exc_pkg::exc_vec_e   vec_sel;

  exc_event_sampler u_sampler (
    .clk         (clk),
    .rst_n       (rst_n),
    .illegal_i   (illegal_i),
    .ecall_i     (ecall_i),
    .ebreak_i    (ebreak_i),
    .eret_i      (eret_i),
    .load_err_i  (load_err_i),
    .store_err_i (store_err_i),
    .irq_i       (irq_i),
    .irq_id_i    (irq_id_i),
    .pc_i        (pc_i),
    .ev_o        (ev),
    .pc_o        (pc_q)
  );

  exc_controller u_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .ev_i           (ev),
    .irq_enable_i   (irq_enable_o),
    .dbg_settings_i (dbg_settings_i),
    .ack_i          (ack),
    .int_req_o      (int_req),
    .ext_req_o      (ext_req),
    .save_cause_o   (save_cause),
    .trap_o         (trap_o),
    .cause_o        (cause),
    .vec_sel_o      (vec_sel)
  );

  exc_flush_sequencer #(
    .PIPE_DEPTH (PIPE_DEPTH)
  ) u_flush (
    .clk       (clk),
    .rst_n     (rst_n),
    .int_req_i (int_req),
    .ext_req_i (ext_req),
    .stall_i   (stall_i),
    .ack_o     (ack)
  );

  exc_trap_csr #(
    .VEC_BASE (VEC_BASE)
  ) u_csr (
    .clk             (clk),
    .rst_n           (rst_n),
    .ev_i            (ev),
    .pc_i            (pc_q),
    .save_cause_i    (save_cause),
    .cause_i         (cause),
    .vec_sel_i       (vec_sel),
    .irq_enable_o    (irq_enable_o),
    .cause_o         (cause_o),
    .epc_o           (epc_o),
    .handler_pc_o    (handler_pc_o),
    .handler_valid_o (handler_valid_o)
  );

endmodule

// File: source/exc_trap_csr.sv
////////////////////
// trap csr block
// cause, epc and interrupt enable with its saved copy
// turns the vector selector into a handler address, eret jumps back to epc
////////////////////

`timescale 1ns/100ps

module exc_trap_csr #(
  parameter logic [31:0] VEC_BASE = 32'h0000_1000
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  exc_pkg::exc_event_t    ev_i,
  input  logic [31:0]            pc_i,
  input  logic                   save_cause_i,
  input  exc_pkg::exc_cause_u    cause_i,
  input  exc_pkg::exc_vec_e      vec_sel_i,
  output logic                   irq_enable_o,
  output logic [5:0]             cause_o,
  output logic [31:0]            epc_o,
  output logic [31:0]            handler_pc_o,
  output logic                   handler_valid_o
);

  logic                irq_enable_saved_q;
  logic                busy_q;
  logic                req_seen;
  logic [31:0]         pc_hold_q;
  logic [31:0]         target;
  exc_pkg::exc_vec_e   vec_eff;

  // same request condition as the controller, to catch the first-cycle pc
  assign req_seen = ev_i.illegal | ev_i.ecall | ev_i.load_err | ev_i.store_err
                  | (ev_i.irq & irq_enable_o);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (save_cause_i) begin
      busy_q <= 1'b0;
    end else if (req_seen) begin
      busy_q <= 1'b1;
    end
  end

  // pc of the instruction that raised the request
  always_ff @(posedge clk) begin
    if (!busy_q && req_seen) begin
      pc_hold_q <= pc_i;
    end
  end

  ////////////////////
  // handler address
  ////////////////////

  // eret shares the address mux with a selector of its own
  assign vec_eff = save_cause_i ? vec_sel_i : exc_pkg::VEC_ERET;

  always_comb begin
    case (vec_eff)
      exc_pkg::VEC_IRQ:     target = VEC_BASE + exc_pkg::VEC_OFF_IRQ
                                   + {25'd0, cause_i.irq.id, 2'b00};
      exc_pkg::VEC_ECALL:   target = VEC_BASE + exc_pkg::VEC_OFF_ECALL;
      exc_pkg::VEC_ILLINSN: target = VEC_BASE + exc_pkg::VEC_OFF_ILL;
      exc_pkg::VEC_LOAD:    target = VEC_BASE + exc_pkg::VEC_OFF_LOAD;
      exc_pkg::VEC_STORE:   target = VEC_BASE + exc_pkg::VEC_OFF_STORE;
      exc_pkg::VEC_ERET:    target = epc_o;
      default:              target = VEC_BASE;
    endcase
  end

  // trap entry has priority over a return in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_enable_o       <= 1'b1;
      // a stray eret leaves interrupts on
      irq_enable_saved_q <= 1'b1;
      cause_o            <= '0;
      epc_o              <= '0;
      handler_pc_o       <= '0;
      handler_valid_o    <= 1'b0;
    end else begin
      handler_valid_o <= save_cause_i | ev_i.eret;
      if (save_cause_i) begin
        cause_o            <= cause_i;
        epc_o              <= pc_hold_q;
        handler_pc_o       <= target;
        irq_enable_saved_q <= irq_enable_o;
        irq_enable_o       <= 1'b0;
      end else if (ev_i.eret) begin
        handler_pc_o <= target;
        irq_enable_o <= irq_enable_saved_q;
      end
    end
  end

endmodule

// File: source/exc_flush_sequencer.sv
////////////////////
// stand-in for the core controller
// drains the pipeline for a pending request and returns a one-cycle ack
////////////////////

`timescale 1ns/100ps

module exc_flush_sequencer #(
  parameter int PIPE_DEPTH = 3
) (
  input  logic clk,
  input  logic rst_n,
  input  logic int_req_i,
  input  logic ext_req_i,
  // back-pressure, freezes the drain count
  input  logic stall_i,
  output logic ack_o
);

  localparam int CNT_W = $clog2(PIPE_DEPTH + 1);

  logic             req;
  logic             last;
  logic [CNT_W-1:0] cnt_q;

  assign req = int_req_i | ext_req_i;

  // last unstalled drain cycle, ack follows on the next edge
  assign last = (cnt_q == CNT_W'(PIPE_DEPTH - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      ack_o <= 1'b0;
    end else if (ack_o) begin
      // request drops on ack, count restarts for the next one
      cnt_q <= '0;
      ack_o <= 1'b0;
    end else if (req && !stall_i) begin
      if (last) begin
        cnt_q <= '0;
        ack_o <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: source/exc_controller.sv
////////////////////
// exception controller
// prioritizes events, picks cause and vector, raises the debug trap
// holds an internal or external request until the flush sequencer acks
////////////////////

`timescale 1ns/100ps

module exc_controller (
  input  logic                              clk,
  input  logic                              rst_n,
  input  exc_pkg::exc_event_t               ev_i,
  // enable bit from the csr block
  input  logic                              irq_enable_i,
  input  logic [exc_pkg::DBG_SETS_W-1:0]    dbg_settings_i,
  // handshake with the flush sequencer
  input  logic                              ack_i,
  output logic                              int_req_o,
  output logic                              ext_req_o,
  // to the csr block
  output logic                              save_cause_o,
  output logic                              trap_o,
  output exc_pkg::exc_cause_u               cause_o,
  output exc_pkg::exc_vec_e                 vec_sel_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_INT,
    WAIT_EXT
  } exc_state_e;

  exc_state_e          state_q;
  exc_state_e          state_d;

  logic                irq_taken;
  logic                int_req_int;
  logic                ext_req_int;
  logic                req_int;
  logic                new_req;

  exc_pkg::exc_cause_u cause_int;
  exc_pkg::exc_cause_u cause_q;
  exc_pkg::exc_vec_e   vec_int;
  exc_pkg::exc_vec_e   vec_q;

  // interrupt only counts when the csr enable is set
  assign irq_taken = ev_i.irq & irq_enable_i;

  ////////////////////
  // debug trap
  ////////////////////

  // single-step forces the trap, every other source needs its own bit
  assign trap_o = dbg_settings_i[exc_pkg::DBG_SSTE]
                | (ev_i.ecall     & dbg_settings_i[exc_pkg::DBG_ECALL])
                | (ev_i.load_err  & dbg_settings_i[exc_pkg::DBG_ELSU])
                | (ev_i.store_err & dbg_settings_i[exc_pkg::DBG_ELSU])
                | (ev_i.ebreak    & dbg_settings_i[exc_pkg::DBG_EBRK])
                | (ev_i.illegal   & dbg_settings_i[exc_pkg::DBG_EILL])
                | (irq_taken      & dbg_settings_i[exc_pkg::DBG_IRQ]);

  // internal requests come from the decoder, external ones from lsu and irq
  assign int_req_int = ev_i.ecall | ev_i.illegal;
  assign ext_req_int = ev_i.load_err | ev_i.store_err | irq_taken;
  assign req_int     = int_req_int | ext_req_int;

  // first cycle of a request
  assign new_req = (state_q == IDLE) && req_int;

  ////////////////////
  // cause and vector
  ////////////////////

  // later assignment wins, so priority rises down the list
  always_comb begin
    cause_int = '0;
    vec_int   = exc_pkg::VEC_IRQ;
    if (irq_taken) begin
      cause_int.irq.is_irq = 1'b1;
      cause_int.irq.id     = ev_i.irq_id;
      vec_int              = exc_pkg::VEC_IRQ;
    end
    // ebreak sets a cause for debug only, no vector
    if (ev_i.ebreak) begin
      cause_int          = '0;
      cause_int.exc.code = exc_pkg::CODE_EBREAK;
    end
    if (ev_i.ecall) begin
      cause_int          = '0;
      cause_int.exc.code = exc_pkg::CODE_ECALL;
      vec_int            = exc_pkg::VEC_ECALL;
    end
    if (ev_i.illegal) begin
      cause_int          = '0;
      cause_int.exc.code = exc_pkg::CODE_ILLEGAL;
      vec_int            = exc_pkg::VEC_ILLINSN;
    end
    if (ev_i.load_err) begin
      cause_int          = '0;
      cause_int.exc.code = exc_pkg::CODE_LOAD;
      vec_int            = exc_pkg::VEC_LOAD;
    end
    if (ev_i.store_err) begin
      cause_int          = '0;
      cause_int.exc.code = exc_pkg::CODE_STORE;
      vec_int            = exc_pkg::VEC_STORE;
    end
  end

  // hold cause and vector from the first request cycle until ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cause_q <= '0;
      vec_q   <= exc_pkg::VEC_IRQ;
    end else if (new_req) begin
      cause_q <= cause_int;
      vec_q   <= vec_int;
    end
  end

  // idle bypass; ebreak shows its cause even without a request
  assign cause_o   = (new_req || ev_i.ebreak) ? cause_int : cause_q;
  assign vec_sel_o = new_req ? vec_int : vec_q;

  ////////////////////
  // request fsm
  ////////////////////

  always_comb begin
    state_d      = state_q;
    int_req_o    = 1'b0;
    ext_req_o    = 1'b0;
    save_cause_o = 1'b0;
    case (state_q)
      IDLE: begin
        // internal wins when both are raised
        int_req_o = int_req_int;
        ext_req_o = ext_req_int & ~int_req_int;
        if (req_int) begin
          state_d = int_req_int ? WAIT_INT : WAIT_EXT;
          if (ack_i) begin
            save_cause_o = 1'b1;
            state_d      = IDLE;
          end
        end
      end
      WAIT_INT: begin
        int_req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = IDLE;
        end
      end
      WAIT_EXT: begin
        ext_req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: source/exc_event_sampler.sv
////////////////////
// input side of the trap path
// synchronizes the async interrupt and registers all strobes as one event word
// the pc is delayed one cycle so it lines up with the event word
////////////////////

`timescale 1ns/100ps

module exc_event_sampler (
  input  logic                   clk,
  input  logic                   rst_n,
  // decoder strobes, one-cycle pulses
  input  logic                   illegal_i,
  input  logic                   ecall_i,
  input  logic                   ebreak_i,
  input  logic                   eret_i,
  // load/store unit errors
  input  logic                   load_err_i,
  input  logic                   store_err_i,
  // asynchronous interrupt level and its id
  input  logic                   irq_i,
  input  logic [4:0]             irq_id_i,
  // pc of the current instruction
  input  logic [31:0]            pc_i,
  output exc_pkg::exc_event_t    ev_o,
  output logic [31:0]            pc_o
);

  // two-flop synchronizer for the interrupt line
  logic       irq_meta;
  logic       irq_sync;
  // id follows the synchronizer stages, held stable by the source while irq is up
  logic [4:0] irq_id_s1;
  logic [4:0] irq_id_s2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_meta <= 1'b0;
      irq_sync <= 1'b0;
    end else begin
      irq_meta <= irq_i;
      irq_sync <= irq_meta;
    end
  end

  always_ff @(posedge clk) begin
    irq_id_s1 <= irq_id_i;
    irq_id_s2 <= irq_id_s1;
  end

  // event word, one register stage after the pins
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ev_o <= '0;
    end else begin
      ev_o.illegal   <= illegal_i;
      ev_o.ecall     <= ecall_i;
      ev_o.ebreak    <= ebreak_i;
      ev_o.eret      <= eret_i;
      ev_o.load_err  <= load_err_i;
      ev_o.store_err <= store_err_i;
      // irq arrives third cycle after the pin rises
      ev_o.irq       <= irq_sync;
      ev_o.irq_id    <= irq_id_s2;
    end
  end

  // pc aligned with ev_o
  always_ff @(posedge clk) begin
    pc_o <= pc_i;
  end

endmodule

// File: source/exc_pkg.sv
////////////////////
// shared types and constants of the trap-entry subsystem
// event word, cause union, vector selector, debug bits and cause codes
// referenced by scoped name from the RTL and the testbench
////////////////////

package exc_pkg;

  // one registered cycle of events, as seen by the controller and csr block
  typedef struct packed {
    logic       illegal;
    logic       ecall;
    logic       ebreak;
    logic       eret;
    logic       load_err;
    logic       store_err;
    logic       irq;
    logic [4:0] irq_id;
  } exc_event_t;

  // cause word read as an interrupt with its id
  typedef struct packed {
    logic       is_irq;
    logic [4:0] id;
  } irq_cause_t;

  // cause word read as a synchronous exception code
  typedef struct packed {
    logic       is_irq;
    logic [4:0] code;
  } exc_code_t;

  // msb tells which view applies
  typedef union packed {
    irq_cause_t irq;
    exc_code_t  exc;
  } exc_cause_u;

  // handler vector selector
  typedef enum logic [2:0] {
    VEC_IRQ     = 3'd0,
    VEC_ECALL   = 3'd1,
    VEC_ILLINSN = 3'd2,
    VEC_LOAD    = 3'd3,
    VEC_STORE   = 3'd4,
    VEC_ERET    = 3'd5
  } exc_vec_e;

  // exception codes, low five bits of the cause word
  localparam logic [4:0] CODE_ILLEGAL = 5'd2;
  localparam logic [4:0] CODE_EBREAK  = 5'd3;
  localparam logic [4:0] CODE_LOAD    = 5'd5;
  localparam logic [4:0] CODE_STORE   = 5'd7;
  localparam logic [4:0] CODE_ECALL   = 5'd11;

  // debug settings, one enable bit per trap source
  localparam int DBG_SETS_W = 6;
  localparam int DBG_SSTE   = 0;
  localparam int DBG_ECALL  = 1;
  localparam int DBG_ELSU   = 2;
  localparam int DBG_EBRK   = 3;
  localparam int DBG_EILL   = 4;
  localparam int DBG_IRQ    = 5;

  // handler offsets in bytes from the vector base
  localparam logic [31:0] VEC_OFF_IRQ   = 32'h0000_0000;
  localparam logic [31:0] VEC_OFF_ECALL = 32'h0000_0080;
  localparam logic [31:0] VEC_OFF_ILL   = 32'h0000_0084;
  localparam logic [31:0] VEC_OFF_LOAD  = 32'h0000_0088;
  localparam logic [31:0] VEC_OFF_STORE = 32'h0000_008C;

endpackage
